// File: all.f
src/lz77_pkg.sv
src/lz77_buf_if.sv
src/lz77_ctrl.sv
src/lz77_window.sv
src/lz77_match.sv
src/lz77_top.sv
verif/lz77_properties.sv
verif/tb_lz77_top.sv

// File: verif/tb_lz77_top.sv
/*
 * Testbench for the LZ77 block compressor. Feeds random blocks through
 * a FIFO model and checks every token against a greedy reference model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lz77_top;

  localparam int NUM_BLK = 30;
  localparam int MAX_BLK = 256;

  logic            clk = 1'b0;
  logic            rstn;
  logic            start_i;
  lz77_pkg::blk_t  cfg_len_i;
  lz77_pkg::byte_t fifo_rd_dat_i;
  logic            fifo_rd_val_o;
  logic            val_o;
  logic            flg_lit_o;
  lz77_pkg::byte_t dat_lit_o;
  lz77_pkg::len_t  dat_len_o;
  lz77_pkg::dst_t  dat_dst_o;
  logic            flg_lst_o;
  logic            done_o;

  integer          seed;
  lz77_pkg::byte_t blk_dat [0:MAX_BLK-1];
  int              blk_len_tab [0:NUM_BLK-1];
  int              exp_lit [0:MAX_BLK-1];
  int              exp_byte [0:MAX_BLK-1];
  int              exp_len [0:MAX_BLK-1];
  int              exp_dst [0:MAX_BLK-1];
  int              n_exp;
  int              rd_ptr;
  int              errors = 0;
  int              tok_total = 0;
  int              total_bytes = 0;
  int              wd_cycles = 0;
  int              cur_blk;
  int              cur_tok;
  int              b;

  lz77_top dut0 (
    .clk           (clk),
    .rstn          (rstn),
    .start_i       (start_i),
    .cfg_len_i     (cfg_len_i),
    .fifo_rd_dat_i (fifo_rd_dat_i),
    .fifo_rd_val_o (fifo_rd_val_o),
    .val_o         (val_o),
    .flg_lit_o     (flg_lit_o),
    .dat_lit_o     (dat_lit_o),
    .dat_len_o     (dat_len_o),
    .dat_dst_o     (dat_dst_o),
    .flg_lst_o     (flg_lst_o),
    .done_o        (done_o)
  );

  always #10 clk = ~clk;

  // --------------------
  // FIFO model returns data one cycle after each read strobe
  always @(posedge clk) begin
    if (start_i) begin
      rd_ptr <= 0;
    end else if (fifo_rd_val_o) begin
      fifo_rd_dat_i <= blk_dat[rd_ptr];
      rd_ptr        <= rd_ptr + 1;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h (block %0d, token %0d)",
               name, got, exp, cur_blk, cur_tok);
    end
  endtask

  // kind 0 full byte range, kind 1 two symbols, kind 2 periodic with rare breaks
  task automatic fill_block(input int kind, input int len);
    int              per;
    lz77_pkg::byte_t sym_a;
    sym_a = $random(seed);
    per   = 1 + {$random(seed)} % 6;
    for (int i = 0; i < len; i++) begin
      case (kind)
        0: blk_dat[i] = $random(seed);
        1: blk_dat[i] = ($random(seed) & 1) ? sym_a : (sym_a ^ 8'h5a);
        default: begin
          if ((i < per) || (({$random(seed)} % 16) == 0)) begin
            blk_dat[i] = $random(seed);
          end else begin
            blk_dat[i] = blk_dat[i - per];
          end
        end
      endcase
    end
  endtask

  // --------------------
  // greedy reference picks the longest match and the nearest distance on a tie
  task automatic build_model(input int len);
    int pos;
    int lim;
    int d;
    int l;
    int best_len;
    int best_dst;
    n_exp = 0;
    pos   = 0;
    while (pos < len) begin
      best_len = 0;
      best_dst = 0;
      lim      = (pos < lz77_pkg::DST_MAX) ? pos : lz77_pkg::DST_MAX;
      for (d = 1; d <= lim; d++) begin
        l = 0;
        // match may not reach into the bytes it describes
        while ((l < lz77_pkg::LEN_MAX) && (pos + l < len) && (l < d) &&
               (blk_dat[pos + l] == blk_dat[pos + l - d])) begin
          l++;
        end
        if (l > best_len) begin
          best_len = l;
          best_dst = d;
        end
      end
      if (best_len < lz77_pkg::LEN_MIN) begin
        exp_lit[n_exp]  = 1;
        exp_byte[n_exp] = blk_dat[pos];
        exp_len[n_exp]  = 1;
        exp_dst[n_exp]  = 0;
      end else begin
        exp_lit[n_exp]  = 0;
        exp_byte[n_exp] = 0;
        exp_len[n_exp]  = best_len;
        exp_dst[n_exp]  = best_dst;
      end
      pos += exp_len[n_exp];
      n_exp++;
    end
  endtask

  task automatic run_block(input int blk);
    int len;
    int n_rd;
    int n_tok;
    int len_sum;
    bit done_seen;
    len = blk_len_tab[blk];
    fill_block(blk % 3, len);
    build_model(len);
    cur_blk   = blk;
    n_rd      = 0;
    n_tok     = 0;
    len_sum   = 0;
    done_seen = 1'b0;
    start_i   <= 1'b1;
    cfg_len_i <= lz77_pkg::blk_t'(len);
    @(posedge clk);
    start_i <= 1'b0;
    while (!done_seen) begin
      @(posedge clk);
      if (fifo_rd_val_o) begin
        n_rd++;
      end
      if (val_o) begin
        cur_tok = n_tok;
        if (n_tok >= n_exp) begin
          errors++;
          $display("block %0d produced more tokens than the model expects", blk);
        end else begin
          check_val("flg_lit_o", flg_lit_o, exp_lit[n_tok]);
          check_val("dat_lit_o", dat_lit_o, exp_byte[n_tok]);
          check_val("dat_len_o", dat_len_o, exp_len[n_tok]);
          check_val("dat_dst_o", dat_dst_o, exp_dst[n_tok]);
          check_val("flg_lst_o", flg_lst_o, n_tok == n_exp - 1);
          check_val("done_o", done_o, n_tok == n_exp - 1);
        end
        len_sum += dat_len_o;
        n_tok++;
      end
      done_seen = done_o;
    end
    if (n_rd != len) begin
      errors++;
      $display("block %0d read the FIFO %0d times for %0d bytes", blk, n_rd, len);
    end
    if ((n_tok != n_exp) || (len_sum != len)) begin
      errors++;
      $display("block %0d gave %0d tokens covering %0d bytes, model has %0d tokens for %0d",
               blk, n_tok, len_sum, n_exp, len);
    end
    tok_total += n_tok;
  endtask

  // --------------------
  // watchdog sized from the block lengths
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: the blocks did not finish within %0d cycles", wd_cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    seed          = 32'h6221e5ee;
    rstn          = 1'b0;
    start_i       = 1'b0;
    cfg_len_i     = '0;
    fifo_rd_dat_i = '0;
    // edge lengths first, then random ones
    for (b = 0; b < NUM_BLK; b++) begin
      case (b)
        0: blk_len_tab[b] = 1;
        1: blk_len_tab[b] = 2;
        2: blk_len_tab[b] = 3;
        3, 4, 5: blk_len_tab[b] = 255;
        default: blk_len_tab[b] = 1 + {$random(seed)} % 255;
      endcase
      total_bytes += blk_len_tab[b];
    end
    wd_cycles = total_bytes * (lz77_pkg::LEN_MAX + 4) + NUM_BLK * 16 + 200;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    repeat (2) @(posedge clk);
    for (b = 0; b < NUM_BLK; b++) begin
      run_block(b);
    end
    @(posedge clk);
    $display("blocks %0d, bytes %0d, tokens %0d, errors %0d, assertion failures %0d",
             NUM_BLK, total_bytes, tok_total, errors, dut0.props0.fail_cnt);
    if ((errors == 0) && (dut0.props0.fail_cnt == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/lz77_properties.sv
/*
 * Concurrent checks on the top-level strobes and token fields,
 * bound into every lz77_top instance.
 */
`timescale 1ns/1ps
`default_nettype none

module lz77_properties (
  input logic            clk,
  input logic            rstn,
  input logic            fifo_rd_val_i,
  input logic            val_i,
  input logic            flg_lit_i,
  input lz77_pkg::byte_t dat_lit_i,
  input lz77_pkg::len_t  dat_len_i,
  input lz77_pkg::dst_t  dat_dst_i,
  input logic            flg_lst_i,
  input logic            done_i
);

  int fail_cnt = 0;

  // strobes come out of reset low
  rst_low: assert property (@(posedge clk)
    $rose(rstn) |-> !val_i && !done_i && !fifo_rd_val_i)
    else begin
      fail_cnt++;
      $error("strobe high right after reset");
    end

  done_with_last: assert property (@(posedge clk) disable iff (!rstn)
    done_i |-> val_i && flg_lst_i)
    else begin
      fail_cnt++;
      $error("done without a last token");
    end

  // token fields idle at zero
  fields_idle: assert property (@(posedge clk) disable iff (!rstn)
    !val_i |-> !flg_lit_i && (dat_lit_i == '0) && (dat_len_i == '0) && (dat_dst_i == '0))
    else begin
      fail_cnt++;
      $error("token fields nonzero without a token");
    end

endmodule

bind lz77_top lz77_properties props0 (
  .clk           (clk),
  .rstn          (rstn),
  .fifo_rd_val_i (fifo_rd_val_o),
  .val_i         (val_o),
  .flg_lit_i     (flg_lit_o),
  .dat_lit_i     (dat_lit_o),
  .dat_len_i     (dat_len_o),
  .dat_dst_i     (dat_dst_o),
  .flg_lst_i     (flg_lst_o),
  .done_i        (done_o)
);

`default_nettype wire

// File: src/lz77_top.sv
/*
 * LZ77 compressor top level. Connects controller, buffer and matcher
 * to the FIFO read port and the token output port.
 */
`timescale 1ns/1ps
`default_nettype none

module lz77_top (
  input  logic            clk,
  input  logic            rstn,
  input  logic            start_i,
  input  lz77_pkg::blk_t  cfg_len_i,
  input  lz77_pkg::byte_t fifo_rd_dat_i,
  output logic            fifo_rd_val_o,
  output logic            val_o,
  output logic            flg_lit_o,
  output lz77_pkg::byte_t dat_lit_o,
  output lz77_pkg::len_t  dat_len_o,
  output lz77_pkg::dst_t  dat_dst_o,
  output logic            flg_lst_o,
  output logic            done_o
);

  logic           fill_req;
  logic           fill_done;
  logic           sch_start;
  logic           tok_val;
  lz77_pkg::len_t tok_len;
  lz77_pkg::len_t consume;

  lz77_buf_if bif0 ();

  // --------------------
  // block controller
  lz77_ctrl ctrl0 (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (start_i),
    .cfg_len_i (cfg_len_i),
    .fill_done (fill_done),
    .tok_val   (tok_val),
    .tok_len   (tok_len),
    .fill_req  (fill_req),
    .sch_start (sch_start),
    .consume   (consume),
    .val_o     (val_o),
    .flg_lst_o (flg_lst_o),
    .done_o    (done_o)
  );

  // window and look-ahead
  lz77_window win0 (
    .clk           (clk),
    .rstn          (rstn),
    .start_i       (start_i),
    .cfg_len_i     (cfg_len_i),
    .fill_req      (fill_req),
    .consume       (consume),
    .fifo_rd_dat_i (fifo_rd_dat_i),
    .fill_done     (fill_done),
    .fifo_rd_val_o (fifo_rd_val_o),
    .buf_o         (bif0.src)
  );

  // match search
  lz77_match match0 (
    .clk       (clk),
    .rstn      (rstn),
    .sch_start (sch_start),
    .buf_i     (bif0.snk),
    .tok_val   (tok_val),
    .tok_len   (tok_len),
    .flg_lit_o (flg_lit_o),
    .dat_lit_o (dat_lit_o),
    .dat_len_o (dat_len_o),
    .dat_dst_o (dat_dst_o)
  );

endmodule

`default_nettype wire

// File: src/lz77_match.sv
/*
 * Match search: one candidate flag per distance, one look-ahead byte
 * compared per cycle, greedy best token with the nearest distance.
 */
`timescale 1ns/1ps
`default_nettype none

module lz77_match (
  input  logic            clk,
  input  logic            rstn,
  input  logic            sch_start,
  lz77_buf_if.snk         buf_i,
  output logic            tok_val,
  output lz77_pkg::len_t  tok_len,
  output logic            flg_lit_o,
  output lz77_pkg::byte_t dat_lit_o,
  output lz77_pkg::len_t  dat_len_o,
  output lz77_pkg::dst_t  dat_dst_o
);

  // bit j stands for distance j+1
  logic [lz77_pkg::DST_MAX-1:0] flg_q;
  logic [lz77_pkg::DST_MAX-1:0] flg_nxt;
  logic [lz77_pkg::DST_MAX-1:0] flg_vld;
  logic                         act_q;
  lz77_pkg::len_t               k_q;
  lz77_pkg::len_t               k_inc;
  logic                         any_nxt;
  logic                         cmp_end;
  logic                         tok_lit;
  lz77_pkg::dst_t               near_dst;
  lz77_pkg::len_t               bst_len_q;
  lz77_pkg::len_t               bst_len_nxt;
  lz77_pkg::dst_t               bst_dst_q;
  lz77_pkg::dst_t               bst_dst_nxt;
  logic                         out_vld_q;
  logic                         flg_lit_q;
  lz77_pkg::byte_t              dat_lit_q;
  lz77_pkg::len_t               dat_len_q;
  lz77_pkg::dst_t               dat_dst_q;

  // --------------------
  // candidate flags
  always_comb begin
    for (int j = 0; j < lz77_pkg::DST_MAX; j++) begin
      flg_vld[j] = (j < int'(buf_i.len_win));
    end
  end

  // step k compares inp[k] with the byte at distance d-k until k reaches d
  always_comb begin
    for (int j = 0; j < lz77_pkg::DST_MAX; j++) begin
      if (int'(k_q) <= j) begin
        flg_nxt[j] = flg_q[j] && (buf_i.inp[k_q] == buf_i.win[j - int'(k_q)]);
      end else begin
        flg_nxt[j] = 1'b0;
      end
    end
  end

  assign any_nxt = |flg_nxt;
  assign k_inc   = k_q + 1'b1;
  assign cmp_end = !any_nxt || (k_inc >= buf_i.len_inp);

  // --------------------
  // nearest-candidate detector
  always_comb begin
    near_dst = '0;
    for (int j = lz77_pkg::DST_MAX - 1; j >= 0; j--) begin
      if (flg_nxt[j]) begin
        near_dst = lz77_pkg::dst_t'(j + 1);
      end
    end
  end

  // --------------------
  // best token so far
  always_comb begin
    bst_len_nxt = bst_len_q;
    bst_dst_nxt = bst_dst_q;
    if (sch_start) begin
      bst_len_nxt = lz77_pkg::len_t'(1);
      bst_dst_nxt = '0;
    end else if (act_q && any_nxt && (k_inc <= buf_i.len_inp)) begin
      bst_len_nxt = k_inc;
      bst_dst_nxt = near_dst;
    end
  end

  // an empty window ends the search in its first cycle
  assign tok_val = (sch_start && (buf_i.len_win == '0)) || (act_q && cmp_end);
  assign tok_lit = bst_len_nxt < lz77_pkg::len_t'(lz77_pkg::LEN_MIN);
  assign tok_len = tok_lit ? lz77_pkg::len_t'(1) : bst_len_nxt;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      act_q     <= 1'b0;
      k_q       <= '0;
      flg_q     <= '0;
      out_vld_q <= 1'b0;
    end else begin
      out_vld_q <= tok_val;
      if (sch_start) begin
        act_q <= (buf_i.len_win != '0);
        k_q   <= '0;
        flg_q <= flg_vld;
      end else if (act_q) begin
        k_q   <= k_inc;
        flg_q <= flg_nxt;
        if (cmp_end) begin
          act_q <= 1'b0;
        end
      end
    end
  end

  // literals carry the head byte, matches carry length and distance
  always_ff @(posedge clk) begin
    bst_len_q <= bst_len_nxt;
    bst_dst_q <= bst_dst_nxt;
    if (tok_val) begin
      flg_lit_q <= tok_lit;
      dat_lit_q <= tok_lit ? buf_i.inp[0] : '0;
      dat_len_q <= tok_len;
      dat_dst_q <= tok_lit ? '0 : bst_dst_nxt;
    end
  end

  assign flg_lit_o = out_vld_q ? flg_lit_q : 1'b0;
  assign dat_lit_o = out_vld_q ? dat_lit_q : '0;
  assign dat_len_o = out_vld_q ? dat_len_q : '0;
  assign dat_dst_o = out_vld_q ? dat_dst_q : '0;

endmodule

`default_nettype wire

// File: src/lz77_window.sv
/*
 * Sliding window and look-ahead buffer. On each fill request it moves
 * the consumed bytes into the window, then reads the FIFO byte by byte
 * until the look-ahead is as full as the rest of the block allows.
 */
`timescale 1ns/1ps
`default_nettype none

module lz77_window (
  input  logic            clk,
  input  logic            rstn,
  input  logic            start_i,
  input  lz77_pkg::blk_t  cfg_len_i,
  input  logic            fill_req,
  input  lz77_pkg::len_t  consume,
  input  lz77_pkg::byte_t fifo_rd_dat_i,
  output logic            fill_done,
  output logic            fifo_rd_val_o,
  lz77_buf_if.src         buf_o
);

  lz77_pkg::byte_t [lz77_pkg::DST_MAX-1:0] win_q;
  lz77_pkg::byte_t [lz77_pkg::DST_MAX-1:0] win_shf;
  lz77_pkg::byte_t [lz77_pkg::LEN_MAX-1:0] inp_q;
  lz77_pkg::byte_t [lz77_pkg::LEN_MAX-1:0] inp_shf;
  lz77_pkg::dst_t                          len_win_q;
  lz77_pkg::dst_t                          len_win_sum;
  lz77_pkg::len_t                          len_inp_q;
  lz77_pkg::len_t                          len_inp_left;
  lz77_pkg::len_t                          inp_space;
  lz77_pkg::len_t                          fet_need;
  lz77_pkg::len_t                          rd_rem_q;
  lz77_pkg::blk_t                          blk_len_q;
  lz77_pkg::blk_t                          cnt_fet_q;
  lz77_pkg::blk_t                          blk_rem;
  logic                                    fill_act_q;
  logic                                    rd_dat_vld_q;

  // --------------------
  // fill target
  assign len_inp_left = len_inp_q - consume;
  assign inp_space    = lz77_pkg::len_t'(lz77_pkg::LEN_MAX) - len_inp_left;
  assign blk_rem      = blk_len_q - cnt_fet_q;
  assign fet_need     = (blk_rem < lz77_pkg::blk_t'(inp_space)) ?
                        lz77_pkg::len_t'(blk_rem) : inp_space;
  assign len_win_sum  = len_win_q + lz77_pkg::dst_t'(consume);

  // consumed bytes enter the window newest first
  always_comb begin
    for (int i = 0; i < lz77_pkg::DST_MAX; i++) begin
      if (i < int'(consume)) begin
        win_shf[i] = inp_q[int'(consume) - 1 - i];
      end else begin
        win_shf[i] = win_q[i - int'(consume)];
      end
    end
  end

  assign inp_shf = inp_q >> (consume * lz77_pkg::DATA_WD);

  // --------------------
  // one read strobe per remaining byte
  assign fifo_rd_val_o = fill_act_q && (rd_rem_q != '0);
  // high in the cycle the last byte comes back
  assign fill_done     = fill_act_q && (rd_rem_q == '0);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      blk_len_q    <= '0;
      cnt_fet_q    <= '0;
      len_win_q    <= '0;
      len_inp_q    <= '0;
      rd_rem_q     <= '0;
      fill_act_q   <= 1'b0;
      rd_dat_vld_q <= 1'b0;
    end else begin
      rd_dat_vld_q <= fifo_rd_val_o;
      if (start_i) begin
        // a zero fill count drops the previous block's window
        blk_len_q  <= cfg_len_i;
        cnt_fet_q  <= '0;
        len_win_q  <= '0;
        len_inp_q  <= '0;
        rd_rem_q   <= '0;
        fill_act_q <= 1'b0;
      end else if (fill_req) begin
        len_win_q  <= (len_win_sum > lz77_pkg::dst_t'(lz77_pkg::DST_MAX)) ?
                      lz77_pkg::dst_t'(lz77_pkg::DST_MAX) : len_win_sum;
        len_inp_q  <= len_inp_left;
        rd_rem_q   <= fet_need;
        fill_act_q <= 1'b1;
      end else begin
        if (fifo_rd_val_o) begin
          rd_rem_q  <= rd_rem_q - 1'b1;
          cnt_fet_q <= cnt_fet_q + 1'b1;
        end
        if (rd_dat_vld_q) begin
          len_inp_q <= len_inp_q + 1'b1;
        end
        if (fill_done) begin
          fill_act_q <= 1'b0;
        end
      end
    end
  end

  // --------------------
  // byte storage
  always_ff @(posedge clk) begin
    if (fill_req) begin
      win_q <= win_shf;
      inp_q <= inp_shf;
    end else if (rd_dat_vld_q) begin
      // append at the tail of the look-ahead
      inp_q[len_inp_q] <= fifo_rd_dat_i;
    end
  end

  assign buf_o.win     = win_q;
  assign buf_o.inp     = inp_q;
  assign buf_o.len_win = len_win_q;
  assign buf_o.len_inp = len_inp_q;

endmodule

`default_nettype wire

// File: src/lz77_ctrl.sv
/*
 * Block controller: steps through fetch and search per token,
 * counts consumed bytes and raises the token, last and done pulses.
 */
`timescale 1ns/1ps
`default_nettype none

module lz77_ctrl (
  input  logic           clk,
  input  logic           rstn,
  input  logic           start_i,
  input  lz77_pkg::blk_t cfg_len_i,
  input  logic           fill_done,
  input  logic           tok_val,
  input  lz77_pkg::len_t tok_len,
  output logic           fill_req,
  output logic           sch_start,
  output lz77_pkg::len_t consume,
  output logic           val_o,
  output logic           flg_lst_o,
  output logic           done_o
);

  lz77_pkg::ctrl_state_t state_q;
  lz77_pkg::ctrl_state_t state_nxt;
  lz77_pkg::blk_t        blk_len_q;
  lz77_pkg::blk_t        cnt_con_q;
  lz77_pkg::blk_t        cnt_con_nxt;
  logic                  last_tok;

  // consumed count including the token finishing now
  assign cnt_con_nxt = cnt_con_q + lz77_pkg::blk_t'(tok_len);
  assign last_tok    = tok_val && (cnt_con_nxt == blk_len_q);

  // --------------------
  // next state
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      lz77_pkg::IDLE: begin
        if (start_i) begin
          state_nxt = lz77_pkg::UPT;
        end
      end
      lz77_pkg::UPT: begin
        if (fill_done) begin
          state_nxt = lz77_pkg::SCH;
        end
      end
      lz77_pkg::SCH: begin
        if (tok_val) begin
          state_nxt = last_tok ? lz77_pkg::IDLE : lz77_pkg::UPT;
        end
      end
      default: state_nxt = lz77_pkg::IDLE;
    endcase
  end

  // --------------------
  // state, counters and pulses
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q   <= lz77_pkg::IDLE;
      blk_len_q <= '0;
      cnt_con_q <= '0;
      consume   <= '0;
      fill_req  <= 1'b0;
      sch_start <= 1'b0;
      val_o     <= 1'b0;
      flg_lst_o <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      state_q   <= state_nxt;
      // one-cycle pulses on state entry
      fill_req  <= (state_nxt == lz77_pkg::UPT) && (state_q != lz77_pkg::UPT);
      sch_start <= (state_nxt == lz77_pkg::SCH) && (state_q != lz77_pkg::SCH);
      val_o     <= tok_val;
      flg_lst_o <= last_tok;
      done_o    <= last_tok;
      if ((state_q == lz77_pkg::IDLE) && start_i) begin
        blk_len_q <= cfg_len_i;
        cnt_con_q <= '0;
        consume   <= '0;
      end else if (tok_val) begin
        cnt_con_q <= cnt_con_nxt;
        consume   <= tok_len;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/lz77_buf_if.sv
/*
 * Window and look-ahead contents with their fill counts.
 * Driven by the buffer block, read by the matcher.
 */
`timescale 1ns/1ps
`default_nettype none

interface lz77_buf_if;

  // win[0] is the most recent byte, distance d sits at win[d-1]
  lz77_pkg::byte_t [lz77_pkg::DST_MAX-1:0] win;
  // inp[0] is the head of the look-ahead
  lz77_pkg::byte_t [lz77_pkg::LEN_MAX-1:0] inp;
  lz77_pkg::dst_t                          len_win;
  lz77_pkg::len_t                          len_inp;

  modport src (
    output win,
    output inp,
    output len_win,
    output len_inp
  );

  modport snk (
    input win,
    input inp,
    input len_win,
    input len_inp
  );

endinterface

`default_nettype wire

// File: src/lz77_pkg.sv
/*
 * Shared widths, limits and types of the LZ77 block compressor.
 * Design files reach these through scoped names.
 */
`default_nettype none

package lz77_pkg;

  // --------------------
  // symbol and token limits
  localparam int DATA_WD = 8;
  localparam int LEN_MIN = 3;
  localparam int LEN_MAX = 8;
  localparam int DST_MAX = 16;
  localparam int BLK_WD  = 8;

  // field widths wide enough for the largest length and distance
  localparam int LEN_WD = $clog2(LEN_MAX + 1);
  localparam int DST_WD = $clog2(DST_MAX + 1);

  // --------------------
  // vector types
  typedef logic [DATA_WD-1:0] byte_t;
  typedef logic [LEN_WD-1:0]  len_t;
  typedef logic [DST_WD-1:0]  dst_t;
  typedef logic [BLK_WD-1:0]  blk_t;

  // upt fetches and shifts, sch searches one offset step per cycle
  typedef enum logic [1:0] {
    IDLE,
    UPT,
    SCH
  } ctrl_state_t;

endpackage

`default_nettype wire
